// File: common/axi_pkg.sv
package axi_pkg;

   typedef logic [31:0] addr_t;   // Byte address
   typedef logic [63:0] data_t;   // One bus word
   typedef logic [7:0]  strb_t;   // One bit per data byte
   typedef logic [7:0]  len_t;    // Beats minus one
   typedef logic [2:0]  size_t;   // Bytes per beat, log2
   typedef logic [1:0]  burst_t;
   typedef logic [1:0]  resp_t;

   // Response codes
   localparam resp_t RESP_OKAY   = 2'b00;
   localparam resp_t RESP_SLVERR = 2'b10;

   localparam burst_t BURST_INCR = 2'b01;   // Only burst type in use
   localparam size_t  SIZE_8B    = 3'b011;  // Full 64-bit beat

endpackage

// File: common/core_pkg.sv
package core_pkg;

   // Fetch length as beats minus one, 1 to 16 beats
   typedef logic [3:0] fetch_len_t;

   typedef enum logic {
      OP_LOAD  = 1'b0,
      OP_STORE = 1'b1
   } mem_op_e;

endpackage

// File: arbiter/axi_arbiter.sv
`timescale 1ns/1ps

module axi_arbiter import axi_pkg::*; (
   input  logic   clk,
   input  logic   rst,

   // Read address channel
   input  addr_t  araddr_ifu,
   input  addr_t  araddr_mem,
   output addr_t  araddr,
   input  len_t   arlen_ifu,
   input  len_t   arlen_mem,
   output len_t   arlen,
   input  size_t  arsize_ifu,
   input  size_t  arsize_mem,
   output size_t  arsize,
   input  burst_t arburst_ifu,
   input  burst_t arburst_mem,
   output burst_t arburst,
   input  logic   arvalid_ifu,
   input  logic   arvalid_mem,
   output logic   arvalid,
   input  logic   arready,
   output logic   arready_ifu,
   output logic   arready_mem,

   // Read data channel
   input  data_t  rdata,
   output data_t  rdata_ifu,
   output data_t  rdata_mem,
   input  resp_t  rresp,
   output resp_t  rresp_ifu,
   output resp_t  rresp_mem,
   input  logic   rlast,
   output logic   rlast_ifu,
   output logic   rlast_mem,
   input  logic   rvalid,
   output logic   rvalid_ifu,
   output logic   rvalid_mem,
   input  logic   rready_ifu,
   input  logic   rready_mem,
   output logic   rready,

   // Write address channel
   input  addr_t  awaddr_ifu,
   input  addr_t  awaddr_mem,
   output addr_t  awaddr,
   input  len_t   awlen_ifu,
   input  len_t   awlen_mem,
   output len_t   awlen,
   input  size_t  awsize_ifu,
   input  size_t  awsize_mem,
   output size_t  awsize,
   input  burst_t awburst_ifu,
   input  burst_t awburst_mem,
   output burst_t awburst,
   input  logic   awvalid_ifu,
   input  logic   awvalid_mem,
   output logic   awvalid,
   input  logic   awready,
   output logic   awready_ifu,
   output logic   awready_mem,

   // Write data channel
   input  data_t  wdata_ifu,
   input  data_t  wdata_mem,
   output data_t  wdata,
   input  strb_t  wstrb_ifu,
   input  strb_t  wstrb_mem,
   output strb_t  wstrb,
   input  logic   wlast_ifu,
   input  logic   wlast_mem,
   output logic   wlast,
   input  logic   wvalid_ifu,
   input  logic   wvalid_mem,
   output logic   wvalid,
   input  logic   wready,
   output logic   wready_ifu,
   output logic   wready_mem,

   // Write response channel
   input  resp_t  bresp,
   output resp_t  bresp_ifu,
   output resp_t  bresp_mem,
   input  logic   bvalid,
   output logic   bvalid_ifu,
   output logic   bvalid_mem,
   input  logic   bready_ifu,
   input  logic   bready_mem,
   output logic   bready
);

   typedef enum logic [2:0] {
      R_IDLE,
      R_ADDR_IFU,
      R_ADDR_MEM,
      R_DATA_IFU,
      R_DATA_MEM
   } r_state_e;

   r_state_e r_state, r_state_nx;
   logic ar_ifu, ar_mem;   // Address phase grant
   logic r_ifu, r_mem;     // Data phase grant

   always_ff @(posedge clk) begin
      if (rst) r_state <= R_IDLE;
      else     r_state <= r_state_nx;
   end

   always_comb begin
      r_state_nx = r_state;
      case (r_state)
         R_IDLE: begin
            if (arvalid_ifu)      r_state_nx = R_ADDR_IFU;  // Fetch has priority
            else if (arvalid_mem) r_state_nx = R_ADDR_MEM;
         end
         R_ADDR_IFU: if (arvalid && arready) r_state_nx = R_DATA_IFU;
         R_ADDR_MEM: if (arvalid && arready) r_state_nx = R_DATA_MEM;
         // Grant held for the whole burst
         R_DATA_IFU, R_DATA_MEM: if (rvalid && rready && rlast) r_state_nx = R_IDLE;
         default: r_state_nx = R_IDLE;
      endcase
   end

   assign ar_ifu = (r_state == R_ADDR_IFU);
   assign ar_mem = (r_state == R_ADDR_MEM);
   assign r_ifu  = (r_state == R_DATA_IFU);
   assign r_mem  = (r_state == R_DATA_MEM);

   // AR passes through only while granted
   assign araddr  = ar_ifu ? araddr_ifu  : ar_mem ? araddr_mem  : '0;
   assign arlen   = ar_ifu ? arlen_ifu   : ar_mem ? arlen_mem   : '0;
   assign arsize  = ar_ifu ? arsize_ifu  : ar_mem ? arsize_mem  : '0;
   assign arburst = ar_ifu ? arburst_ifu : ar_mem ? arburst_mem : '0;
   assign arvalid = ar_ifu ? arvalid_ifu : ar_mem ? arvalid_mem : 1'b0;
   assign arready_ifu = ar_ifu & arready;
   assign arready_mem = ar_mem & arready;

   // R beats steered to the granted master only
   assign rdata_ifu  = r_ifu ? rdata  : '0;
   assign rresp_ifu  = r_ifu ? rresp  : '0;
   assign rlast_ifu  = r_ifu & rlast;
   assign rvalid_ifu = r_ifu & rvalid;
   assign rdata_mem  = r_mem ? rdata  : '0;
   assign rresp_mem  = r_mem ? rresp  : '0;
   assign rlast_mem  = r_mem & rlast;
   assign rvalid_mem = r_mem & rvalid;
   assign rready     = r_ifu ? rready_ifu : r_mem ? rready_mem : 1'b0;

   // Writes only from load/store side
   assign awaddr      = awaddr_mem;
   assign awlen       = awlen_mem;
   assign awsize      = awsize_mem;
   assign awburst     = awburst_mem;
   assign awvalid     = awvalid_mem;
   assign awready_mem = awready;
   assign awready_ifu = 1'b0;
   assign wdata       = wdata_mem;
   assign wstrb       = wstrb_mem;
   assign wlast       = wlast_mem;
   assign wvalid      = wvalid_mem;
   assign wready_mem  = wready;
   assign wready_ifu  = 1'b0;
   assign bresp_mem   = bresp;
   assign bvalid_mem  = bvalid;
   assign bready      = bready_mem;
   assign bresp_ifu   = '0;
   assign bvalid_ifu  = 1'b0;

   // Slave sees no AR request on the idle cycle after a burst
   a_no_ar_in_idle: assert property (@(posedge clk) disable iff (rst)
      rvalid && rready && rlast |=> !arvalid);

   // Fetch master must never start a write
   a_ifu_no_write: assert property (@(posedge clk) disable iff (rst)
      !awvalid_ifu && !wvalid_ifu);

endmodule

// File: hdl/ifu_axi_master.sv
`timescale 1ns/1ps

module ifu_axi_master import axi_pkg::*, core_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       fetch_req,
   input  addr_t      fetch_addr,
   input  fetch_len_t fetch_len,
   output logic       fetch_busy,
   output logic       fetch_beat,
   output data_t      fetch_data,
   output resp_t      fetch_resp,
   output logic       fetch_done,
   output addr_t      araddr,
   output len_t       arlen,
   output size_t      arsize,
   output burst_t     arburst,
   output logic       arvalid,
   input  logic       arready,
   input  data_t      rdata,
   input  resp_t      rresp,
   input  logic       rlast,
   input  logic       rvalid,
   output logic       rready,
   output logic       awvalid,
   output logic       wvalid,
   output logic       bready
);

   typedef enum logic [1:0] {F_IDLE, F_ADDR, F_DATA} f_state_e;

   f_state_e   state;
   addr_t      addr_q;   // Latched fetch address
   fetch_len_t len_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= F_IDLE;
      end else begin
         case (state)
            F_IDLE: begin
               if (fetch_req) begin
                  state  <= F_ADDR;
                  addr_q <= fetch_addr;
                  len_q  <= fetch_len;
               end
            end
            F_ADDR: if (arready) state <= F_DATA;  // Stall here until AR accepted
            F_DATA: if (rvalid && rlast) state <= F_IDLE;
            default: state <= F_IDLE;
         endcase
      end
   end

   assign fetch_busy = (state != F_IDLE);

   // One INCR burst of 8-byte beats
   assign araddr  = {addr_q[31:3], 3'b000};
   assign arlen   = len_t'(len_q);
   assign arsize  = SIZE_8B;
   assign arburst = BURST_INCR;
   assign arvalid = (state == F_ADDR);
   assign rready  = 1'b1;

   assign fetch_beat = (state == F_DATA) & rvalid;
   assign fetch_data = rdata;
   assign fetch_resp = rresp;
   assign fetch_done = fetch_beat & rlast;   // Comes with last beat

   // No write traffic from fetch
   assign awvalid = 1'b0;
   assign wvalid  = 1'b0;
   assign bready  = 1'b0;

   a_no_req_while_busy: assert property (@(posedge clk) disable iff (rst)
      fetch_req |-> !fetch_busy);

endmodule

// File: hdl/lsu_axi_master.sv
`timescale 1ns/1ps

module lsu_axi_master import axi_pkg::*, core_pkg::*; (
   input  logic    clk,
   input  logic    rst,
   input  logic    lsu_req,
   input  mem_op_e lsu_op,
   input  addr_t   lsu_addr,
   input  data_t   lsu_wdata,
   input  strb_t   lsu_wstrb,
   output logic    lsu_busy,
   output logic    lsu_done,
   output data_t   lsu_rdata,
   output resp_t   lsu_resp,
   output addr_t   araddr,
   output len_t    arlen,
   output size_t   arsize,
   output burst_t  arburst,
   output logic    arvalid,
   input  logic    arready,
   input  data_t   rdata,
   input  resp_t   rresp,
   input  logic    rlast,
   input  logic    rvalid,
   output logic    rready,
   output addr_t   awaddr,
   output len_t    awlen,
   output size_t   awsize,
   output burst_t  awburst,
   output logic    awvalid,
   input  logic    awready,
   output data_t   wdata,
   output strb_t   wstrb,
   output logic    wlast,
   output logic    wvalid,
   input  logic    wready,
   input  resp_t   bresp,
   input  logic    bvalid,
   output logic    bready
);

   typedef enum logic [2:0] {
      L_IDLE,
      L_RADDR,
      L_RDATA,
      L_WADDR,
      L_WDATA,
      L_WRESP
   } l_state_e;

   l_state_e state;
   addr_t    addr_q;
   data_t    wdata_q;   // Store payload
   strb_t    wstrb_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= L_IDLE;
      end else begin
         case (state)
            L_IDLE: begin
               if (lsu_req) begin
                  state   <= (lsu_op == OP_LOAD) ? L_RADDR : L_WADDR;
                  addr_q  <= lsu_addr;
                  wdata_q <= lsu_wdata;
                  wstrb_q <= lsu_wstrb;
               end
            end
            L_RADDR: if (arready) state <= L_RDATA;
            L_RDATA: if (rvalid && rlast) state <= L_IDLE;  // Single beat
            L_WADDR: if (awready) state <= L_WDATA;
            L_WDATA: if (wready) state <= L_WRESP;
            L_WRESP: if (bvalid) state <= L_IDLE;
            default: state <= L_IDLE;
         endcase
      end
   end

   assign lsu_busy = (state != L_IDLE);

   // Read side, word aligned
   assign araddr  = {addr_q[31:3], 3'b000};
   assign arlen   = '0;
   assign arsize  = SIZE_8B;
   assign arburst = BURST_INCR;
   assign arvalid = (state == L_RADDR);
   assign rready  = 1'b1;

   // Write side
   assign awaddr  = {addr_q[31:3], 3'b000};
   assign awlen   = '0;
   assign awsize  = SIZE_8B;
   assign awburst = BURST_INCR;
   assign awvalid = (state == L_WADDR);
   assign wdata   = wdata_q;
   assign wstrb   = wstrb_q;
   assign wvalid  = (state == L_WDATA);
   assign wlast   = (state == L_WDATA);   // Every W beat is the last
   assign bready  = 1'b1;

   // Done on R beat for loads, on B for stores
   assign lsu_done  = ((state == L_RDATA) & rvalid) | ((state == L_WRESP) & bvalid);
   assign lsu_rdata = (state == L_RDATA) ? rdata : '0;
   assign lsu_resp  = (state == L_RDATA) ? rresp : bresp;

endmodule

// File: hdl/axi_sram.sv
`timescale 1ns/1ps

module axi_sram import axi_pkg::*; #(
   parameter int MEM_WORDS = 256
) (
   input  logic   clk,
   input  logic   rst,
   input  addr_t  araddr,
   input  len_t   arlen,
   input  size_t  arsize,
   input  burst_t arburst,
   input  logic   arvalid,
   output logic   arready,
   output data_t  rdata,
   output resp_t  rresp,
   output logic   rlast,
   output logic   rvalid,
   input  logic   rready,
   input  addr_t  awaddr,
   input  len_t   awlen,
   input  size_t  awsize,
   input  burst_t awburst,
   input  logic   awvalid,
   output logic   awready,
   input  data_t  wdata,
   input  strb_t  wstrb,
   input  logic   wlast,
   input  logic   wvalid,
   output logic   wready,
   output resp_t  bresp,
   output logic   bvalid,
   input  logic   bready
);

   localparam int    IDX_W     = $clog2(MEM_WORDS);
   localparam addr_t MEM_BYTES = addr_t'(MEM_WORDS * 8);

   typedef enum logic [1:0] {S_IDLE, S_RDATA, S_WDATA, S_WRESP} s_state_e;

   s_state_e           state;
   data_t              mem [MEM_WORDS];
   addr_t              addr_q;    // Current beat address, reads and writes
   len_t               len_q;
   len_t               cnt_q;     // Beats sent so far
   resp_t              bresp_q;
   logic               in_range;
   logic [IDX_W-1:0]   idx;

   assign in_range = (addr_q < MEM_BYTES);
   assign idx      = addr_q[IDX_W+2:3];

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= S_IDLE;
      end else begin
         case (state)
            S_IDLE: begin
               if (arvalid) begin   // Read wins over write
                  state  <= S_RDATA;
                  addr_q <= araddr;
                  len_q  <= arlen;
                  cnt_q  <= '0;
               end else if (awvalid) begin
                  state  <= S_WDATA;
                  addr_q <= awaddr;
               end
            end
            S_RDATA: begin
               if (rready) begin
                  addr_q <= addr_q + 32'd8;   // INCR step of one word
                  cnt_q  <= cnt_q + 8'd1;
                  if (rlast) state <= S_IDLE;
               end
            end
            S_WDATA: begin
               if (wvalid) begin
                  state   <= S_WRESP;
                  bresp_q <= in_range ? RESP_OKAY : RESP_SLVERR;
               end
            end
            S_WRESP: if (bready) state <= S_IDLE;
            default: state <= S_IDLE;
         endcase
      end
   end

   // Byte merge, out-of-range write dropped
   always_ff @(posedge clk) begin
      if (state == S_WDATA && wvalid && in_range) begin
         for (int i = 0; i < 8; i++) begin
            if (wstrb[i]) mem[idx][i*8 +: 8] <= wdata[i*8 +: 8];
         end
      end
   end

   assign arready = (state == S_IDLE);
   assign awready = (state == S_IDLE) & !arvalid;
   assign wready  = (state == S_WDATA);

   assign rvalid = (state == S_RDATA);
   assign rlast  = rvalid & (cnt_q == len_q);
   assign rdata  = in_range ? mem[idx] : '0;   // Zero data on SLVERR
   assign rresp  = in_range ? RESP_OKAY : RESP_SLVERR;

   assign bvalid = (state == S_WRESP);
   assign bresp  = bresp_q;

   a_incr_only: assert property (@(posedge clk) disable iff (rst)
      arvalid && arready |-> arburst == BURST_INCR);

endmodule

// File: hdl/axi_mem_subsys.sv
`timescale 1ns/1ps

module axi_mem_subsys import axi_pkg::*, core_pkg::*; #(
   parameter int MEM_WORDS = 256
) (
   input  logic       clk,
   input  logic       rst,
   input  logic       fetch_req,
   input  addr_t      fetch_addr,
   input  fetch_len_t fetch_len,
   output logic       fetch_busy,
   output logic       fetch_beat,
   output data_t      fetch_data,
   output resp_t      fetch_resp,
   output logic       fetch_done,
   input  logic       lsu_req,
   input  mem_op_e    lsu_op,
   input  addr_t      lsu_addr,
   input  data_t      lsu_wdata,
   input  strb_t      lsu_wstrb,
   output logic       lsu_busy,
   output logic       lsu_done,
   output data_t      lsu_rdata,
   output resp_t      lsu_resp
);

   // Master side _ifu and _mem, slave side unsuffixed
   wire addr_t  araddr_ifu, araddr_mem, araddr, awaddr_mem, awaddr;
   wire len_t   arlen_ifu, arlen_mem, arlen, awlen_mem, awlen;
   wire size_t  arsize_ifu, arsize_mem, arsize, awsize_mem, awsize;
   wire burst_t arburst_ifu, arburst_mem, arburst, awburst_mem, awburst;
   wire data_t  rdata_ifu, rdata_mem, rdata, wdata_mem, wdata;
   wire strb_t  wstrb_mem, wstrb;
   wire resp_t  rresp_ifu, rresp_mem, rresp, bresp_mem, bresp;
   wire logic   arvalid_ifu, arvalid_mem, arvalid, arready_ifu, arready_mem, arready;
   wire logic   rlast_ifu, rlast_mem, rlast, rvalid_ifu, rvalid_mem, rvalid;
   wire logic   rready_ifu, rready_mem, rready;
   wire logic   awvalid_ifu, awvalid_mem, awvalid, awready_mem, awready;
   wire logic   wlast_mem, wlast, wvalid_ifu, wvalid_mem, wvalid, wready_mem, wready;
   wire logic   bvalid_mem, bvalid, bready_ifu, bready_mem, bready;

   ifu_axi_master u_ifu (
      .clk, .rst, .fetch_req, .fetch_addr, .fetch_len,
      .fetch_busy, .fetch_beat, .fetch_data, .fetch_resp, .fetch_done,
      .araddr(araddr_ifu), .arlen(arlen_ifu), .arsize(arsize_ifu),
      .arburst(arburst_ifu), .arvalid(arvalid_ifu), .arready(arready_ifu),
      .rdata(rdata_ifu), .rresp(rresp_ifu), .rlast(rlast_ifu),
      .rvalid(rvalid_ifu), .rready(rready_ifu),
      .awvalid(awvalid_ifu), .wvalid(wvalid_ifu), .bready(bready_ifu)
   );

   lsu_axi_master u_lsu (
      .clk, .rst, .lsu_req, .lsu_op, .lsu_addr, .lsu_wdata, .lsu_wstrb,
      .lsu_busy, .lsu_done, .lsu_rdata, .lsu_resp,
      .araddr(araddr_mem), .arlen(arlen_mem), .arsize(arsize_mem),
      .arburst(arburst_mem), .arvalid(arvalid_mem), .arready(arready_mem),
      .rdata(rdata_mem), .rresp(rresp_mem), .rlast(rlast_mem),
      .rvalid(rvalid_mem), .rready(rready_mem),
      .awaddr(awaddr_mem), .awlen(awlen_mem), .awsize(awsize_mem),
      .awburst(awburst_mem), .awvalid(awvalid_mem), .awready(awready_mem),
      .wdata(wdata_mem), .wstrb(wstrb_mem), .wlast(wlast_mem),
      .wvalid(wvalid_mem), .wready(wready_mem),
      .bresp(bresp_mem), .bvalid(bvalid_mem), .bready(bready_mem)
   );

   // Fetch write fields unused, response side left open
   axi_arbiter u_arb (
      .awaddr_ifu('0), .awlen_ifu('0), .awsize_ifu('0), .awburst_ifu('0),
      .wdata_ifu('0), .wstrb_ifu('0), .wlast_ifu(1'b0),
      .awready_ifu(), .wready_ifu(), .bresp_ifu(), .bvalid_ifu(),
      .*
   );

   axi_sram #(.MEM_WORDS(MEM_WORDS)) u_sram (.*);

endmodule

// File: dv/axi_mem_subsys_tb.sv
`timescale 1ns/1ps

module axi_mem_subsys_tb import axi_pkg::*, core_pkg::*; ();

   localparam int MEM_WORDS      = 256;
   localparam int NUM_FIXED      = 12;
   localparam int NUM_ROWS       = 28;    // Fixed rows, then random store/load pairs
   localparam int TIMEOUT_CYCLES = 100;

   typedef enum logic [1:0] {K_STORE, K_LOAD, K_FETCH, K_BOTH} kind_e;

   typedef struct {
      kind_e      kind;
      addr_t      addr;    // Load/store address
      addr_t      faddr;   // Fetch address
      data_t      data;
      strb_t      strb;
      fetch_len_t len;     // Beats minus one
      resp_t      resp;    // Expected on lsu_resp
   } row_t;

   logic       clk = 1'b0;
   logic       rst;
   logic       fetch_req;
   addr_t      fetch_addr;
   fetch_len_t fetch_len;
   logic       fetch_busy;
   logic       fetch_beat;
   data_t      fetch_data;
   resp_t      fetch_resp;
   logic       fetch_done;
   logic       lsu_req;
   mem_op_e    lsu_op;
   addr_t      lsu_addr;
   data_t      lsu_wdata;
   strb_t      lsu_wstrb;
   logic       lsu_busy;
   logic       lsu_done;
   data_t      lsu_rdata;
   resp_t      lsu_resp;

   data_t shadow [addr_t];   // Expected memory, keyed by aligned word address
   row_t  table_rows [NUM_ROWS];
   int    seed;

   axi_mem_subsys #(.MEM_WORDS(MEM_WORDS)) u_dut (.*);

   always #50 clk = ~clk;   // 100 ns period

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Simulation FAILED");
      $fatal(1);
   endtask

   task automatic check_data(input string name, input data_t got, input data_t exp);
      if (got !== exp)
         abort_run($sformatf("error at %0d ns: %s is %h, expected %h", $time, name, got, exp));
   endtask

   task automatic check_resp(input string name, input resp_t got, input resp_t exp);
      if (got !== exp)
         abort_run($sformatf("error at %0d ns: %s is %b, expected %b", $time, name, got, exp));
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp)
         abort_run($sformatf("error at %0d ns: %s is %0d, expected %0d", $time, name, got, exp));
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
         abort_run($sformatf("error at %0d ns: %s is %b, expected %b", $time, name, got, exp));
   endtask

   function automatic addr_t word_of(input addr_t a);
      return {a[31:3], 3'b000};
   endfunction

   function automatic row_t make_row(input kind_e kind, input addr_t addr, input addr_t faddr,
                                     input data_t data, input strb_t strb,
                                     input fetch_len_t len, input resp_t resp);
      row_t r;
      r.kind  = kind;
      r.addr  = addr;
      r.faddr = faddr;
      r.data  = data;
      r.strb  = strb;
      r.len   = len;
      r.resp  = resp;
      return r;
   endfunction

   // One-cycle strobes, driven 1 ns after the edge
   task automatic start_requests(input row_t r, input logic want_fetch, input logic want_lsu);
      @(posedge clk);
      #1;
      fetch_req  = want_fetch;
      fetch_addr = r.faddr;
      fetch_len  = r.len;
      lsu_req    = want_lsu;
      lsu_op     = (r.kind == K_STORE) ? OP_STORE : OP_LOAD;
      lsu_addr   = r.addr;
      lsu_wdata  = r.data;
      lsu_wstrb  = r.strb;
      @(posedge clk);
      #1;
      fetch_req = 1'b0;
      lsu_req   = 1'b0;
      @(negedge clk);   // Busy must be up the cycle after the strobe
      if (want_fetch) check_flag("fetch_busy", fetch_busy, 1'b1);
      if (want_lsu) check_flag("lsu_busy", lsu_busy, 1'b1);
   endtask

   // Outputs sampled mid-cycle
   task automatic collect_results(input row_t r, input logic want_fetch, input logic want_lsu,
                                  input data_t exp_rdata);
      int   beats;
      int   cycle;
      int   fetch_at;
      int   lsu_at;
      logic fetch_seen;
      logic lsu_seen;
      beats      = 0;
      cycle      = 0;
      fetch_at   = 0;
      lsu_at     = 0;
      fetch_seen = !want_fetch;   // Already closed when not requested
      lsu_seen   = !want_lsu;
      while (!(fetch_seen && lsu_seen) && cycle < TIMEOUT_CYCLES) begin
         @(negedge clk);
         cycle++;
         if (fetch_beat) begin
            check_flag("fetch_beat outside an open fetch", fetch_seen, 1'b0);
            check_data("fetch_data", fetch_data, shadow[word_of(r.faddr) + addr_t'(beats * 8)]);
            check_resp("fetch_resp", fetch_resp, RESP_OKAY);
            beats++;
         end
         if (fetch_done) begin
            check_flag("fetch_beat with fetch_done", fetch_beat, 1'b1);
            check_count("fetch beat count", beats, int'(r.len) + 1);
            fetch_seen = 1'b1;
            fetch_at   = cycle;
         end
         if (lsu_done) begin
            check_flag("lsu_done outside an open access", lsu_seen, 1'b0);
            check_resp("lsu_resp", lsu_resp, r.resp);
            check_data("lsu_rdata", lsu_rdata, exp_rdata);
            lsu_seen = 1'b1;
            lsu_at   = cycle;
         end
      end
      if (!(fetch_seen && lsu_seen))
         abort_run("Timeout: fetch_done or lsu_done never arrived");
      // Fetch wins the shared read path
      if (want_fetch && want_lsu) check_flag("fetch_done before lsu_done", fetch_at < lsu_at, 1'b1);
   endtask

   task automatic wait_idle();
      int cycle;
      cycle = 0;
      while ((fetch_busy || lsu_busy) && cycle < TIMEOUT_CYCLES) begin
         @(negedge clk);
         cycle++;
      end
      if (fetch_busy || lsu_busy)
         abort_run("Timeout: fetch_busy or lsu_busy stayed high after done");
   endtask

   task automatic exec_row(input row_t r);
      logic  want_fetch;
      logic  want_lsu;
      data_t exp_rdata;
      addr_t key;
      want_fetch = (r.kind == K_FETCH) || (r.kind == K_BOTH);
      want_lsu   = (r.kind != K_FETCH);
      key        = word_of(r.addr);
      // Stores and errored loads return zero
      if (r.kind == K_STORE || r.resp == RESP_SLVERR) exp_rdata = '0;
      else exp_rdata = shadow[key];
      start_requests(r, want_fetch, want_lsu);
      collect_results(r, want_fetch, want_lsu, exp_rdata);
      wait_idle();
      if (r.kind == K_STORE && r.resp == RESP_OKAY) begin   // Byte merge into shadow
         for (int i = 0; i < 8; i++) begin
            if (r.strb[i]) shadow[key][i*8 +: 8] = r.data[i*8 +: 8];
         end
      end
   endtask

   // Full-word stores over the whole SRAM, pattern from the address
   task automatic fill_memory();
      addr_t a;
      for (int w = 0; w < MEM_WORDS; w++) begin
         a = addr_t'(w * 8);
         exec_row(make_row(K_STORE, a, '0, {a ^ 32'hC3A5_96E1, ~a}, 8'hFF, '0, RESP_OKAY));
      end
   endtask

   task automatic build_table();
      addr_t a;
      table_rows[0]  = make_row(K_STORE, 32'h28, '0, 64'h1122_3344_5566_7788, 8'h0F, '0,
                                RESP_OKAY);
      table_rows[1]  = make_row(K_LOAD, 32'h28, '0, '0, '0, '0, RESP_OKAY);
      table_rows[2]  = make_row(K_STORE, 32'h35, '0, 64'hDEAD_BEEF_CAFE_F00D, 8'hA5, '0,
                                RESP_OKAY);   // Unaligned, word 6
      table_rows[3]  = make_row(K_LOAD, 32'h30, '0, '0, '0, '0, RESP_OKAY);
      table_rows[4]  = make_row(K_FETCH, '0, 32'h20, '0, '0, 4'd7, RESP_OKAY);
      table_rows[5]  = make_row(K_FETCH, '0, 32'h7C0, '0, '0, 4'd7, RESP_OKAY);  // Top words
      table_rows[6]  = make_row(K_BOTH, 32'h28, 32'h40, '0, '0, 4'd3, RESP_OKAY);
      table_rows[7]  = make_row(K_BOTH, 32'h7F8, 32'h100, '0, '0, 4'd0, RESP_OKAY);
      table_rows[8]  = make_row(K_LOAD, 32'h1000, '0, '0, '0, '0, RESP_SLVERR);
      table_rows[9]  = make_row(K_STORE, 32'h1000, '0, '1, 8'hFF, '0, RESP_SLVERR);
      table_rows[10] = make_row(K_LOAD, 32'h800, '0, '0, '0, '0, RESP_SLVERR);  // First bad word
      table_rows[11] = make_row(K_FETCH, '0, 32'h0, '0, '0, 4'd15, RESP_OKAY);  // Word 0 intact
      for (int i = NUM_FIXED; i < NUM_ROWS; i += 2) begin
         a = addr_t'($random(seed)) & addr_t'(MEM_WORDS * 8 - 1);
         table_rows[i]     = make_row(K_STORE, a, '0, {$random(seed), $random(seed)},
                                      strb_t'($random(seed)), '0, RESP_OKAY);
         table_rows[i + 1] = make_row(K_LOAD, a, '0, '0, '0, '0, RESP_OKAY);
      end
   endtask

   initial begin
      seed       = 54;
      rst        = 1'b1;
      fetch_req  = 1'b0;
      fetch_addr = '0;
      fetch_len  = '0;
      lsu_req    = 1'b0;
      lsu_op     = OP_LOAD;
      lsu_addr   = '0;
      lsu_wdata  = '0;
      lsu_wstrb  = '0;
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;
      @(negedge clk);
      // Quiet outputs out of reset
      check_flag("fetch_busy", fetch_busy, 1'b0);
      check_flag("lsu_busy", lsu_busy, 1'b0);
      check_flag("fetch_beat", fetch_beat, 1'b0);
      check_flag("fetch_done", fetch_done, 1'b0);
      check_flag("lsu_done", lsu_done, 1'b0);
      fill_memory();
      build_table();
      for (int i = 0; i < NUM_ROWS; i++) begin
         exec_row(table_rows[i]);
      end
      $display("Simulation PASSED");
      $finish;
   end

endmodule

// File: axi_mem_subsys.f
common/axi_pkg.sv
common/core_pkg.sv
arbiter/axi_arbiter.sv
hdl/ifu_axi_master.sv
hdl/lsu_axi_master.sv
hdl/axi_sram.sv
hdl/axi_mem_subsys.sv
dv/axi_mem_subsys_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timescale 1ns/1ps --top-module axi_mem_subsys_tb \
   -f axi_mem_subsys.f -o sim_axi_mem_subsys \
   && ./obj_dir/sim_axi_mem_subsys > sim.log 2>&1
grep -q "Simulation PASSED" sim.log && echo "Run passed, see sim.log" \
   || { echo "Run failed, see sim.log"; exit 1; }
